// ==== hdl/rename_pkg.sv ====
// Sizes, index types and commit/recovery structs shared by every commit rename module
package rename_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================
  localparam int unsigned PHY_REG_NUM  = 64;
  localparam int unsigned ARCH_REG_NUM = 32;
  localparam int unsigned COMMIT_WIDTH = 2;
  localparam int unsigned FREE_NUM     = PHY_REG_NUM - ARCH_REG_NUM;

  localparam int unsigned PREG_W = $clog2(PHY_REG_NUM);
  localparam int unsigned AREG_W = $clog2(ARCH_REG_NUM);
  // Count must reach PHY_REG_NUM itself
  localparam int unsigned CNT_W  = $clog2(PHY_REG_NUM + 1);

  // ==========================================================
  // Types
  // ==========================================================
  typedef logic [PREG_W-1:0] preg_t;
  typedef logic [AREG_W-1:0] areg_t;
  typedef logic [CNT_W-1:0]  fl_cnt_t;

  // One retire slot
  typedef struct packed {
    logic  valid;
    areg_t areg;
    preg_t new_preg;
    preg_t old_preg;
  } commit_slot_t;

  typedef commit_slot_t [COMMIT_WIDTH-1:0] commit_bundle_t;
  typedef preg_t        [PHY_REG_NUM-1:0]  free_list_t;
  typedef preg_t        [ARCH_REG_NUM-1:0] arch_map_t;

  // Snapshot handed to the front end; free_list[0] is the head
  typedef struct packed {
    arch_map_t  map;
    free_list_t free_list;
    fl_cnt_t    free_cnt;
  } recovery_t;

  // ==========================================================
  // Reset values
  // ==========================================================
  // Identity mapping
  function automatic arch_map_t map_reset();
    arch_map_t m;
    for (int i = 0; i < ARCH_REG_NUM; i++) begin
      m[i] = preg_t'(i);
    end
    return m;
  endfunction

  // Pregs above the architectural ones are free, rest unused
  function automatic free_list_t free_list_reset();
    free_list_t fl;
    fl = '0;
    for (int j = 0; j < FREE_NUM; j++) begin
      fl[j] = preg_t'(ARCH_REG_NUM + j);
    end
    return fl;
  endfunction

  localparam arch_map_t  MAP_RST       = map_reset();
  localparam free_list_t FREE_LIST_RST = free_list_reset();
  localparam recovery_t  RECOVERY_RST  = '{
    map:       MAP_RST,
    free_list: FREE_LIST_RST,
    free_cnt:  fl_cnt_t'(FREE_NUM)
  };

endpackage

// ==== hdl/arch_free_list.sv ====
// Architectural free list ring; commits consume at the head and free old pregs at the tail
`timescale 1ns/100ps

module arch_free_list (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rename_pkg::commit_bundle_t commit_i,
  output rename_pkg::free_list_t    fl_next_o,
  output rename_pkg::preg_t         fl_head_next_o,
  output rename_pkg::fl_cnt_t       fl_cnt_next_o
);

  import rename_pkg::*;

  // Per-cycle slot tally, 0..COMMIT_WIDTH
  typedef logic [$clog2(COMMIT_WIDTH + 1)-1:0] slot_cnt_t;

  free_list_t fl_q;
  free_list_t fl_d;
  preg_t      head_q;
  preg_t      head_d;
  preg_t      tail_q;
  preg_t      tail_d;
  fl_cnt_t    cnt_q;
  fl_cnt_t    cnt_d;
  slot_cnt_t  n_alloc;
  slot_cnt_t  n_free;

  // Ring pointer step with explicit wrap
  function automatic preg_t ptr_inc(preg_t ptr);
    if (ptr == preg_t'(PHY_REG_NUM - 1)) begin
      return '0;
    end
    return ptr + preg_t'(1);
  endfunction

  // ==========================================================
  // Next state
  // ==========================================================
  always_comb begin : next_state
    preg_t wr_ptr;
    fl_d    = fl_q;
    head_d  = head_q;
    wr_ptr  = tail_q;
    n_alloc = '0;
    n_free  = '0;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (commit_i[i].valid) begin
        // Preg given at rename is now owned by the arch state
        head_d  = ptr_inc(head_d);
        n_alloc = n_alloc + slot_cnt_t'(1);
        // Previous mapping goes back on the ring, in slot order
        fl_d[wr_ptr] = commit_i[i].old_preg;
        wr_ptr       = ptr_inc(wr_ptr);
        n_free       = n_free + slot_cnt_t'(1);
      end
    end
    tail_d = wr_ptr;
    // Net zero on commit, but kept so full vs empty never aliases
    cnt_d  = cnt_q + fl_cnt_t'(n_free) - fl_cnt_t'(n_alloc);
  end

  // ==========================================================
  // State registers
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fl_q   <= FREE_LIST_RST;
      head_q <= '0;
      tail_q <= preg_t'(FREE_NUM);
      cnt_q  <= fl_cnt_t'(FREE_NUM);
    end else begin
      fl_q   <= fl_d;
      head_q <= head_d;
      tail_q <= tail_d;
      cnt_q  <= cnt_d;
    end
  end

  // Post-edge view so a flush sees its own cycle's commits
  assign fl_next_o      = fl_d;
  assign fl_head_next_o = head_d;
  assign fl_cnt_next_o  = cnt_d;

endmodule

// ==== hdl/arch_map_table.sv ====
// Committed logical-to-physical map; retiring slots overwrite their areg entry
`timescale 1ns/100ps

module arch_map_table (
  input  logic                       clk,
  input  logic                       rst_n,
  input  rename_pkg::commit_bundle_t commit_i,
  output rename_pkg::arch_map_t      map_next_o
);

  import rename_pkg::*;

  arch_map_t map_q;
  arch_map_t map_d;

  // ==========================================================
  // Commit writes
  // ==========================================================
  // Slots applied low to high
  // so a later slot to the same areg overrides an earlier one
  always_comb begin
    map_d = map_q;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (commit_i[i].valid) begin
        map_d[commit_i[i].areg] = commit_i[i].new_preg;
      end
    end
  end

  // Identity map out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      map_q <= MAP_RST;
    end else begin
      map_q <= map_d;
    end
  end

  // Post-edge map for the snapshot
  assign map_next_o = map_d;

endmodule

// ==== hdl/recovery_snapshot.sv ====
// Builds the head-aligned recovery snapshot from post-commit map and free list on flush
`timescale 1ns/100ps

module recovery_snapshot (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  rename_pkg::free_list_t fl_next_i,
  input  rename_pkg::preg_t      fl_head_next_i,
  input  rename_pkg::fl_cnt_t    fl_cnt_next_i,
  input  rename_pkg::arch_map_t  map_next_i,
  output rename_pkg::recovery_t  recovery_o,
  output logic                   recover_valid_o
);

  import rename_pkg::*;

  free_list_t fl_rot;
  recovery_t  recovery_q;
  logic       recover_valid_q;

  // ==========================================================
  // Rotate free list by head
  // ==========================================================
  // Entry j of the result is ring slot head+j, wrapped
  always_comb begin : rotate
    int unsigned idx;
    for (int unsigned j = 0; j < PHY_REG_NUM; j++) begin
      idx = j + 32'(fl_head_next_i);
      if (idx >= PHY_REG_NUM) begin
        idx = idx - PHY_REG_NUM;
      end
      fl_rot[j] = fl_next_i[idx];
    end
  end

  // ==========================================================
  // Capture
  // ==========================================================
  // Snapshot held until the next flush
  // valid pulses for the single cycle after flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      recovery_q      <= RECOVERY_RST;
      recover_valid_q <= 1'b0;
    end else begin
      recover_valid_q <= flush_i;
      if (flush_i) begin
        recovery_q.map       <= map_next_i;
        recovery_q.free_list <= fl_rot;
        recovery_q.free_cnt  <= fl_cnt_next_i;
      end
    end
  end

  assign recovery_o      = recovery_q;
  assign recover_valid_o = recover_valid_q;

endmodule

// ==== hdl/rename_commit_top.sv ====
// Top of the commit-side rename state; wires free list, map table and snapshot together
`timescale 1ns/100ps

module rename_commit_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  rename_pkg::commit_bundle_t commit_i,
  input  logic                       flush_i,
  output rename_pkg::recovery_t      recovery_o,
  output logic                       recover_valid_o
);

  import rename_pkg::*;

  // Post-commit state into the snapshot block
  free_list_t fl_next;
  preg_t      fl_head_next;
  fl_cnt_t    fl_cnt_next;
  arch_map_t  map_next;

  // Free list ring
  arch_free_list i_arch_free_list (
    .clk            (clk),
    .rst_n          (rst_n),
    .commit_i       (commit_i),
    .fl_next_o      (fl_next),
    .fl_head_next_o (fl_head_next),
    .fl_cnt_next_o  (fl_cnt_next)
  );

  // Arch map
  arch_map_table i_arch_map_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit_i   (commit_i),
    .map_next_o (map_next)
  );

  // Flush capture
  recovery_snapshot i_recovery_snapshot (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (flush_i),
    .fl_next_i       (fl_next),
    .fl_head_next_i  (fl_head_next),
    .fl_cnt_next_i   (fl_cnt_next),
    .map_next_i      (map_next),
    .recovery_o      (recovery_o),
    .recover_valid_o (recover_valid_o)
  );

endmodule

// ==== test/tb_rename_commit.sv ====
// Directed testbench for rename_commit_top; compile with rename_commit.f and run with run_sim.sh
`timescale 1ns/100ps

module tb_rename_commit;

  import rename_pkg::*;

  // Cycles allowed for recover_valid_o after a flush
  localparam int RECOVER_TIMEOUT = 10;

  logic           clk;
  logic           rst_n;
  commit_bundle_t commit_i;
  logic           flush_i;
  recovery_t      recovery_o;
  logic           recover_valid_o;

  // Reference model state
  arch_map_t   model_map;
  preg_t       model_fl[$];
  logic [31:0] rng_state;
  int          total_retired;
  int          mismatch_errs;
  int          other_errs;

  rename_commit_top i_rename_commit_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .commit_i        (commit_i),
    .flush_i         (flush_i),
    .recovery_o      (recovery_o),
    .recover_valid_o (recover_valid_o)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ==========================================================
  // Random numbers and model
  // ==========================================================
  function automatic logic [31:0] xorshift32(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // One retiring slot takes the free front as new preg and frees the old mapping
  task automatic retire(input areg_t a, output commit_slot_t s);
    s          = '0;
    s.valid    = 1'b1;
    s.areg     = a;
    s.new_preg = model_fl.pop_front();
    s.old_preg = model_map[a];
    model_map[a] = s.new_preg;
    model_fl.push_back(s.old_preg);
    total_retired++;
  endtask

  // Each slot valid with 3/4 odds
  task automatic random_bundle(output commit_bundle_t b);
    commit_slot_t slot;
    b = '0;
    for (int s = 0; s < COMMIT_WIDTH; s++) begin
      rng_state = xorshift32(rng_state);
      if (rng_state[1:0] != 2'b00) begin
        retire(areg_t'(rng_state[12:8]), slot);
        b[s] = slot;
      end
    end
  endtask

  // Model free queue laid out as a head-aligned list
  function automatic free_list_t model_free_list();
    free_list_t fl;
    fl = '0;
    for (int j = 0; j < model_fl.size(); j++) begin
      fl[j] = model_fl[j];
    end
    return fl;
  endfunction

  // ==========================================================
  // Compare tasks
  // ==========================================================
  task automatic check_map(input string name, input arch_map_t got, input arch_map_t exp);
    for (int i = 0; i < ARCH_REG_NUM; i++) begin
      if (got[i] !== exp[i]) begin
        $display("MISMATCH %s[%0d]: got 0x%0h expected 0x%0h", name, i, got[i], exp[i]);
        mismatch_errs++;
      end
    end
  endtask

  // Only the first n entries hold free registers
  task automatic check_free_list(input string name, input free_list_t got,
                                 input free_list_t exp, input fl_cnt_t n);
    for (int j = 0; j < int'(n); j++) begin
      if (got[j] !== exp[j]) begin
        $display("MISMATCH %s[%0d]: got 0x%0h expected 0x%0h", name, j, got[j], exp[j]);
        mismatch_errs++;
      end
    end
  endtask

  task automatic check_cnt(input string name, input fl_cnt_t got, input fl_cnt_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      mismatch_errs++;
    end
  endtask

  // Snapshot against the current model state
  task automatic check_snapshot();
    check_map("recovery_o.map", recovery_o.map, model_map);
    check_free_list("recovery_o.free_list", recovery_o.free_list, model_free_list(),
                    fl_cnt_t'(model_fl.size()));
    check_cnt("recovery_o.free_cnt", recovery_o.free_cnt, fl_cnt_t'(model_fl.size()));
  endtask

  // ==========================================================
  // Drivers
  // ==========================================================
  task automatic drive_cycle(input commit_bundle_t b, input logic f);
    @(posedge clk);
    commit_i <= b;
    flush_i  <= f;
  endtask

  // Idle cycles with no recovery pulse expected
  task automatic idle_check(input int n);
    repeat (n) begin
      drive_cycle('0, 1'b0);
      @(negedge clk);
      check_valid("recover_valid_o", recover_valid_o, 1'b0);
    end
  endtask

  // Flush alongside bundle b, then wait for the one-cycle pulse
  task automatic flush_and_check(input commit_bundle_t b);
    logic seen;
    int   late;
    seen = 1'b0;
    late = 0;
    drive_cycle(b, 1'b1);
    drive_cycle('0, 1'b0);
    for (int n = 0; n < RECOVER_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = recover_valid_o;
      late = n;
    end
    if (!seen) begin
      $display("ERROR: recover_valid_o never rose after a flush");
      other_errs++;
    end else begin
      // Pulse belongs to the cycle right after the flush
      if (late != 0) begin
        $display("ERROR: recover_valid_o rose %0d cycles late after a flush", late);
        other_errs++;
      end
      check_snapshot();
      // Pulse lasts a single cycle
      @(negedge clk);
      check_valid("recover_valid_o", recover_valid_o, 1'b0);
    end
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic test_reset();
    for (int i = 0; i < ARCH_REG_NUM; i++) begin
      model_map[i] = preg_t'(i);
    end
    for (int j = 0; j < FREE_NUM; j++) begin
      model_fl.push_back(preg_t'(ARCH_REG_NUM + j));
    end
    idle_check(3);
    // Snapshot register starts at the reset state
    check_snapshot();
    flush_and_check('0);
  endtask

  // Slot 0 and slot 1 in turn, one at a time
  task automatic test_single();
    commit_bundle_t b;
    commit_slot_t   slot;
    for (int k = 0; k < 6; k++) begin
      b = '0;
      rng_state = xorshift32(rng_state);
      retire(areg_t'(rng_state[4:0]), slot);
      b[k % COMMIT_WIDTH] = slot;
      drive_cycle(b, 1'b0);
      flush_and_check('0);
    end
  endtask

  // Same areg in both slots, then distinct aregs
  task automatic test_dual();
    commit_bundle_t b;
    commit_slot_t   slot;
    for (int k = 0; k < 4; k++) begin
      rng_state = xorshift32(rng_state);
      retire(areg_t'(rng_state[4:0]), slot);
      b[0] = slot;
      if (k % 2 == 0) begin
        retire(areg_t'(rng_state[4:0]), slot);
      end else begin
        retire(areg_t'(rng_state[9:5]), slot);
      end
      b[1] = slot;
      drive_cycle(b, 1'b0);
      flush_and_check('0);
    end
  endtask

  // Pointers wrap past PHY_REG_NUM; flush every 16th cycle
  task automatic test_wrap();
    commit_bundle_t b;
    int             start;
    start = total_retired;
    for (int k = 1; k <= 100; k++) begin
      random_bundle(b);
      if (k % 16 == 0) begin
        flush_and_check(b);
      end else begin
        drive_cycle(b, 1'b0);
      end
    end
    flush_and_check('0);
    if (total_retired - start < PHY_REG_NUM) begin
      $display("ERROR: too few commits in the wrap test to wrap the free list");
      other_errs++;
    end
  endtask

  // Commits in the flush cycle land in the snapshot, which then holds
  task automatic test_flush_with_commit();
    commit_bundle_t b;
    commit_slot_t   slot;
    arch_map_t      held_map;
    free_list_t     held_fl;
    fl_cnt_t        held_cnt;
    retire(areg_t'(5), slot);
    b[0] = slot;
    retire(areg_t'(17), slot);
    b[1] = slot;
    flush_and_check(b);
    held_map = model_map;
    held_fl  = model_free_list();
    held_cnt = fl_cnt_t'(model_fl.size());
    for (int k = 0; k < 6; k++) begin
      random_bundle(b);
      drive_cycle(b, 1'b0);
      @(negedge clk);
      check_valid("recover_valid_o", recover_valid_o, 1'b0);
    end
    check_map("recovery_o.map", recovery_o.map, held_map);
    check_free_list("recovery_o.free_list", recovery_o.free_list, held_fl, held_cnt);
    check_cnt("recovery_o.free_cnt", recovery_o.free_cnt, held_cnt);
    // Later commits still reach the next snapshot
    flush_and_check('0);
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    commit_i      = '0;
    flush_i       = 1'b0;
    rng_state     = 32'hf315_c144;
    total_retired = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    test_reset();
    test_single();
    test_dual();
    test_wrap();
    test_flush_with_commit();

    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== rename_commit.f ====
hdl/rename_pkg.sv
hdl/arch_free_list.sv
hdl/arch_map_table.sv
hdl/recovery_snapshot.sv
hdl/rename_commit_top.sv
test/tb_rename_commit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the commit rename testbench with Verilator, run it, and check the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module tb_rename_commit \
  -f rename_commit.f \
  --Mdir obj_dir \
  -o sim_rename_commit

sim_out="$(./obj_dir/sim_rename_commit)"
echo "$sim_out"

if grep -qF '*** PASSED ***' <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
